// File: tb/boardcfg_stimulus.txt
// opcode address data, hex. 1 write, 2 read and compare, 3 stream data frames
// (address bit 0 random gaps, bit 1 full scale), 4 wait cycles, 5 probe half-periods
// one byte per probe, 6 read within one count, 7 read against accumulator model, 0 end.
2 00 00010300
2 0C 00000000
2 10 00000000
2 40 00004000
2 44 00000000
2 54 00004000
2 18 00000000
2 30 00000000
2 20 00000000
1 14 0000A5A5
2 14 000000A5
2 04 00000000
3 00 00000040
1 40 00002000
1 44 0000E000
1 48 0000C000
2 48 FFFFC000
1 5C 00001234
1 60 00003000
1 74 0000F000
3 00 00000040
1 50 00007FFF
1 54 00007FFF
1 58 00007FFF
1 5C 00007FFF
1 60 00008000
1 64 00008000
3 02 00000040
3 00 00000020
5 00 10080402
4 00 00000300
6 20 00000040
6 24 00000020
6 28 00000010
6 2C 00000008
1 08 00000003
2 08 00000003
4 00 00000004
1 04 00000001
3 01 00000014
1 04 00000001
2 0C 00010002
3 01 0000001C
4 00 00000008
2 0C 00030001
7 10 00000000
3 01 0000000A
4 00 00000008
7 10 00000000
2 0C 00030001
1 04 00000002
2 10 00000000
1 08 00000000
1 04 00000001
2 0C 00000001
0 00 00000000

// File: build.f
hw/boardcfg_pkg.sv
hw/axil_regs.sv
hw/freq_counter.sv
hw/coef_mixer.sv
hw/shot_sequencer.sv
hw/boardcfg.sv
tb/boardcfg_tb.sv

// File: Makefile
TOP := boardcfg_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module boardcfg

sim:
	verilator --binary --timing -Wno-fatal -f build.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// File: tb/boardcfg_tb.sv
`timescale 1ns/1ps
`default_nettype none

module boardcfg_tb import boardcfg_pkg::*; ();

	localparam int STIM_LINES = 96;
	localparam int ACCESS_LIMIT = 64;
	localparam logic [31:0] LFSR_MASK = 32'h8020_0003;
	localparam longint SAT_MAX = 32767;
	localparam longint SAT_MIN = -32768;

	logic hw;
	logic reset;
	axil_req_t req;
	axil_rsp_t rsp;
	logic [NPROBE-1:0] probe;
	sample_frame_t adc;
	sample_frame_t dac;
	logic [7:0] leds;

	logic [31:0] stim_mem [0:3*STIM_LINES-1];
	logic [31:0] lfsr;
	int errors;
	int checks;
	int cycles;
	int cycle_limit;
	int half_period [NPROBE];

	// reference model state.
	logic signed [15:0] coef_model [NCH][NCH];
	logic [15:0] nshot_model;
	logic [31:0] acc_model;
	logic run_model;
	int frames_left;
	sample_frame_t expect_pipe [2];

	boardcfg i_dut (
		.hw(hw),
		.reset(reset),
		.axil_req(req),
		.axil_rsp(rsp),
		.probe(probe),
		.adc(adc),
		.dac(dac),
		.leds(leds)
	);

	initial hw = 1'b0;
	always #10 hw = ~hw;

	// galois lfsr, one step per bit.
	function automatic logic next_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_MASK) : (lfsr >> 1);
		return b;
	endfunction

	function automatic logic [15:0] next_word16();
		logic [15:0] w;
		w = '0;
		for (int k = 0; k < 16; k++)
			w = {w[14:0], next_bit()};
		return w;
	endfunction

	// row sums with 14 fraction bits, clipped to 16 bits.
	function automatic sample_frame_t predict(input sample_frame_t f);
		sample_frame_t p;
		longint s;
		p = '0;
		p.valid = f.valid;
		for (int i = 0; i < NCH; i++) begin
			s = 0;
			for (int j = 0; j < NCH; j++)
				s += longint'(coef_model[i][j]) * longint'(f.data[j]);
			s = s >>> COEF_FRAC;
			if (s > SAT_MAX)
				p.data[i] = 16'sh7fff;
			else if (s < SAT_MIN)
				p.data[i] = 16'sh8000;
			else
				p.data[i] = 16'(s);
		end
		return p;
	endfunction

	task automatic note_write(input logic [7:0] addr, input logic [31:0] data);
		if (addr == REG_NSHOT)
			nshot_model = data[15:0];
		if (addr == REG_CTRL) begin
			if (data[1])
				acc_model = '0;
			if (data[0] && !run_model && nshot_model != 0) begin
				run_model = 1'b1;
				frames_left = SHOT_LEN * int'(nshot_model);
			end
		end
		// coefficient block spans 0x40 to 0x7c.
		if (addr[7:6] == 2'b01)
			coef_model[addr[5:4]][addr[3:2]] = data[15:0];
	endtask

	task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
		int waited;
		logic got;
		@(posedge hw);
		#1;
		if (rsp.bvalid) begin
			errors++;
			$display("write response already pending before write to %h", addr);
		end
		req.awvalid = 1'b1;
		req.awaddr = addr;
		req.wvalid = 1'b1;
		req.wdata = data;
		req.wstrb = 4'hf;
		waited = 0;
		do begin
			@(negedge hw);
			waited++;
		end while (!(rsp.awready && rsp.wready) && waited < ACCESS_LIMIT);
		if (!(rsp.awready && rsp.wready)) begin
			errors++;
			$display("write to %h was never accepted", addr);
		end
		@(posedge hw);
		#1;
		req.awvalid = 1'b0;
		req.wvalid = 1'b0;
		note_write(addr, data);
		got = 1'b0;
		waited = 0;
		// bready follows random bits.
		while (!got && waited < ACCESS_LIMIT) begin
			req.bready = next_bit();
			@(negedge hw);
			if (rsp.bvalid && req.bready) begin
				got = 1'b1;
				if (rsp.bresp != 2'b00) begin
					errors++;
					$display("Fail t=%0t bresp got %b expected %b", $time, rsp.bresp, 2'b00);
				end
			end
			@(posedge hw);
			#1;
			waited++;
		end
		req.bready = 1'b0;
		if (!got) begin
			errors++;
			$display("write to %h got no response", addr);
		end
		@(negedge hw);
		if (rsp.bvalid) begin
			errors++;
			$display("write to %h returned a second response", addr);
		end
	endtask

	task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
		int waited;
		logic got;
		data = '0;
		@(posedge hw);
		#1;
		if (rsp.rvalid) begin
			errors++;
			$display("read response already pending before read of %h", addr);
		end
		req.arvalid = 1'b1;
		req.araddr = addr;
		waited = 0;
		do begin
			@(negedge hw);
			waited++;
		end while (!rsp.arready && waited < ACCESS_LIMIT);
		if (!rsp.arready) begin
			errors++;
			$display("read of %h was never accepted", addr);
		end
		@(posedge hw);
		#1;
		req.arvalid = 1'b0;
		got = 1'b0;
		waited = 0;
		while (!got && waited < ACCESS_LIMIT) begin
			req.rready = next_bit();
			@(negedge hw);
			if (rsp.rvalid && req.rready) begin
				got = 1'b1;
				data = rsp.rdata;
				if (rsp.rresp != 2'b00) begin
					errors++;
					$display("Fail t=%0t rresp got %b expected %b", $time, rsp.rresp, 2'b00);
				end
			end
			@(posedge hw);
			#1;
			waited++;
		end
		req.rready = 1'b0;
		if (!got) begin
			errors++;
			$display("read of %h got no response", addr);
		end
		@(negedge hw);
		if (rsp.rvalid) begin
			errors++;
			$display("read of %h returned a second response", addr);
		end
	endtask

	task automatic check_read(input int op, input logic [7:0] addr, input logic [31:0] got,
		input logic [31:0] exp);
		int diff;
		checks++;
		diff = int'(got) - int'(exp);
		if (op == 6) begin
			if (diff > 1 || diff < -1) begin
				errors++;
				$display("Fail t=%0t rdata[%h] got %h expected %h", $time, addr, got, exp);
			end
		end else if (got !== exp) begin
			errors++;
			$display("Fail t=%0t rdata[%h] got %h expected %h", $time, addr, got, exp);
		end
		if (op == 2 && addr == REG_TEST) begin
			checks++;
			if (leds !== exp[7:0]) begin
				errors++;
				$display("Fail t=%0t leds got %h expected %h", $time, leds, exp[7:0]);
			end
		end
	endtask

	task automatic stream_frames(input int n, input logic gaps, input logic full);
		for (int k = 0; k < n; k++) begin
			if (gaps && next_bit()) begin
				@(posedge hw);
				#1;
				adc.valid = 1'b0;
			end
			@(posedge hw);
			#1;
			adc.valid = 1'b1;
			for (int j = 0; j < NCH; j++) begin
				if (full)
					adc.data[j] = next_bit() ? 16'sh7fff : 16'sh8000;
				else
					adc.data[j] = next_word16();
			end
		end
		@(posedge hw);
		#1;
		adc.valid = 1'b0;
	endtask

	// probe toggling, half-periods in hw cycles.
	initial begin
		int ph_cnt [NPROBE];
		probe = '0;
		for (int p = 0; p < NPROBE; p++)
			ph_cnt[p] = 0;
		forever begin
			@(posedge hw);
			#1;
			for (int p = 0; p < NPROBE; p++) begin
				if (half_period[p] != 0) begin
					ph_cnt[p]++;
					if (ph_cnt[p] >= half_period[p]) begin
						probe[p] = ~probe[p];
						ph_cnt[p] = 0;
					end
				end
			end
		end
	end

	// dac is due 2 cycles after adc.
	always @(negedge hw) begin
		if (!reset && (dac.valid || expect_pipe[1].valid)) begin
			checks++;
			if (dac.valid !== expect_pipe[1].valid) begin
				errors++;
				$display("Fail t=%0t dac.valid got %b expected %b", $time, dac.valid,
					expect_pipe[1].valid);
			end else begin
				if (dac.data !== expect_pipe[1].data) begin
					errors++;
					$display("Fail t=%0t dac.data got %h expected %h", $time, dac.data,
						expect_pipe[1].data);
				end
				if (run_model) begin
					acc_model = acc_model + {{16{expect_pipe[1].data[0][15]}},
						expect_pipe[1].data[0]};
					frames_left--;
					if (frames_left == 0)
						run_model = 1'b0;
				end
			end
		end
		expect_pipe[1] = expect_pipe[0];
		expect_pipe[0] = predict(adc);
	end

	always @(posedge hw) begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			errors++;
			$display("timeout, the run did not finish within %0d cycles", cycle_limit);
			$display("checks %0d, errors %0d", checks, errors);
			$display("Some tests failed");
			$finish;
		end
	end

	initial begin
		int op;
		int line;
		int frames;
		int waits;
		int accesses;
		logic [7:0] addr;
		logic [31:0] data;
		logic [31:0] got;
		req = '0;
		adc = '0;
		reset = 1'b1;
		lfsr = 32'he9da69a7;
		errors = 0;
		checks = 0;
		cycles = 0;
		cycle_limit = 0;
		acc_model = '0;
		nshot_model = '0;
		run_model = 1'b0;
		frames_left = 0;
		expect_pipe[0] = '0;
		expect_pipe[1] = '0;
		for (int i = 0; i < NCH; i++)
			for (int j = 0; j < NCH; j++)
				coef_model[i][j] = (i == j) ? 16'sh4000 : 16'sh0000;
		for (int p = 0; p < NPROBE; p++)
			half_period[p] = 0;
		for (int k = 0; k < 3 * STIM_LINES; k++)
			stim_mem[k] = '0;
		$readmemh("tb/boardcfg_stimulus.txt", stim_mem);

		// run length budget from the stimulus.
		frames = 0;
		waits = 0;
		accesses = 0;
		line = 0;
		while (line < STIM_LINES && stim_mem[3*line] != 0) begin
			case (stim_mem[3*line])
				3: frames += int'(stim_mem[3*line+2]);
				4: waits += int'(stim_mem[3*line+2]);
				default: accesses++;
			endcase
			line++;
		end
		if (line == 0) begin
			errors++;
			$display("no stimulus lines were loaded");
		end
		cycle_limit = 2 * (frames + waits + 40 * accesses) + 20;

		repeat (10) @(posedge hw);
		#1;
		reset = 1'b0;

		line = 0;
		while (line < STIM_LINES && stim_mem[3*line] != 0) begin
			op = int'(stim_mem[3*line]);
			addr = stim_mem[3*line+1][7:0];
			data = stim_mem[3*line+2];
			case (op)
				1: reg_write(addr, data);
				2, 6, 7: begin
					reg_read(addr, got);
					if (op == 7)
						data = acc_model;
					check_read(op, addr, got, data);
				end
				3: stream_frames(int'(data), addr[0], addr[1]);
				4: repeat (data) @(posedge hw);
				5: begin
					@(negedge hw);
					for (int p = 0; p < NPROBE; p++)
						half_period[p] = int'(data[8*p +: 8]);
				end
				default: begin
					errors++;
					$display("unknown opcode %0d on stimulus line %0d", op, line);
				end
			endcase
			line++;
		end

		repeat (4) @(posedge hw);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/boardcfg.sv
`timescale 1ns/1ps
`default_nettype none

module boardcfg import boardcfg_pkg::*; (
	input wire logic hw,
	input wire logic reset,
	input wire axil_req_t axil_req,
	output axil_rsp_t axil_rsp,
	input wire logic [NPROBE-1:0] probe,
	input wire sample_frame_t adc,
	output sample_frame_t dac,
	output logic [7:0] leds
);

	coef_matrix_t coef;
	logic [NSHOT_W-1:0] nshot;
	logic start;
	logic acc_clear;
	logic busy;
	logic last_shot_done;
	logic [NSHOT_W-1:0] shot_cnt;
	logic [ACC_W-1:0] acc;
	logic [NPROBE-1:0][FREQ_W-1:0] freq;

	axil_regs i_regs (
		.hw(hw),
		.reset(reset),
		.req(axil_req),
		.rsp(axil_rsp),
		.coef(coef),
		.nshot(nshot),
		.start(start),
		.acc_clear(acc_clear),
		.busy(busy),
		.last_shot_done(last_shot_done),
		.shot_cnt(shot_cnt),
		.acc(acc),
		.freq(freq),
		.leds(leds)
	);

	// one counter per board clock probe.
	for (genvar p = 0; p < NPROBE; p++) begin : gen_freq
		freq_counter i_freq (
			.hw(hw),
			.reset(reset),
			.probe(probe[p]),
			.freq(freq[p])
		);
	end

	coef_mixer i_mixer (
		.hw(hw),
		.reset(reset),
		.coef(coef),
		.in(adc),
		.out(dac)
	);

	// sees the same frames that leave on dac.
	shot_sequencer i_seq (
		.hw(hw),
		.reset(reset),
		.start(start),
		.acc_clear(acc_clear),
		.nshot(nshot),
		.frame(dac),
		.busy(busy),
		.last_shot_done(last_shot_done),
		.shot_cnt(shot_cnt),
		.acc(acc)
	);

endmodule

`default_nettype wire

// File: hw/shot_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module shot_sequencer import boardcfg_pkg::*; (
	input wire logic hw,
	input wire logic reset,
	input wire logic start,
	input wire logic acc_clear,
	input wire logic [NSHOT_W-1:0] nshot,
	input wire sample_frame_t frame,
	output logic busy,
	output logic last_shot_done,
	output logic [NSHOT_W-1:0] shot_cnt,
	output logic [ACC_W-1:0] acc
);

	logic [FRAME_CNT_W-1:0] frame_cnt;
	logic [NSHOT_W-1:0] nshot_q;

	// shot count target, held for the whole run.
	always_ff @(posedge hw) begin
		if (start && !busy)
			nshot_q <= nshot;
	end

	always_ff @(posedge hw) begin
		if (reset) begin
			busy <= 1'b0;
			last_shot_done <= 1'b0;
			shot_cnt <= '0;
			frame_cnt <= '0;
		end else if (!busy) begin
			// start while busy is dropped here.
			if (start) begin
				shot_cnt <= '0;
				frame_cnt <= '0;
				last_shot_done <= (nshot == '0);
				busy <= (nshot != '0);
			end
		end else if (frame.valid) begin
			frame_cnt <= frame_cnt + 1'b1;
			if (frame_cnt == FRAME_CNT_W'(SHOT_LEN - 1)) begin
				shot_cnt <= shot_cnt + 1'b1;
				if (shot_cnt + 1'b1 == nshot_q) begin
					busy <= 1'b0;
					last_shot_done <= 1'b1;
				end
			end
		end
	end

	// channel 0 accumulation, clear wins over add.
	always_ff @(posedge hw) begin
		if (reset || acc_clear) begin
			acc <= '0;
		end else if (busy && frame.valid) begin
			acc <= acc + {{(ACC_W-SAMPLE_W){frame.data[0][SAMPLE_W-1]}}, frame.data[0]};
		end
	end

endmodule

`default_nettype wire

// File: hw/coef_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module coef_mixer import boardcfg_pkg::*; (
	input wire logic hw,
	input wire logic reset,
	input wire coef_matrix_t coef,
	input wire sample_frame_t in,
	output sample_frame_t out
);

	logic signed [PROD_W-1:0] prod_q [NCH][NCH];
	logic valid_q1;
	logic valid_q2;
	sample_t [NCH-1:0] mix_d;
	sample_t [NCH-1:0] mix_q;

	// stage 1, all sixteen products.
	always_ff @(posedge hw) begin
		for (int i = 0; i < NCH; i++) begin
			for (int j = 0; j < NCH; j++) begin
				prod_q[i][j] <= $signed(coef[i][j]) * $signed(in.data[j]);
			end
		end
	end

	// row sums, rescale and saturate.
	always_comb begin
		logic signed [SUM_W-1:0] sum;
		logic signed [SUM_W-1:0] shifted;
		for (int i = 0; i < NCH; i++) begin
			sum = '0;
			for (int j = 0; j < NCH; j++) begin
				sum = sum + prod_q[i][j];
			end
			shifted = sum >>> COEF_FRAC;
			// in range when all bits above the sample sign agree.
			if (&shifted[SUM_W-1:SAMPLE_W-1] || ~|shifted[SUM_W-1:SAMPLE_W-1])
				mix_d[i] = shifted[SAMPLE_W-1:0];
			else if (shifted[SUM_W-1])
				mix_d[i] = {1'b1, {(SAMPLE_W-1){1'b0}}};
			else
				mix_d[i] = {1'b0, {(SAMPLE_W-1){1'b1}}};
		end
	end

	// stage 2.
	always_ff @(posedge hw) begin
		mix_q <= mix_d;
	end

	// valid tracks the data through both stages.
	always_ff @(posedge hw) begin
		if (reset) begin
			valid_q1 <= 1'b0;
			valid_q2 <= 1'b0;
		end else begin
			valid_q1 <= in.valid;
			valid_q2 <= valid_q1;
		end
	end

	assign out.valid = valid_q2;
	assign out.data = mix_q;

endmodule

`default_nettype wire

// File: hw/freq_counter.sv
`timescale 1ns/1ps
`default_nettype none

module freq_counter import boardcfg_pkg::*; (
	input wire logic hw,
	input wire logic reset,
	input wire logic probe,
	output logic [FREQ_W-1:0] freq
);

	logic [1:0] sync;
	logic probe_d;
	logic rise;
	logic [FREQ_GATE_W-1:0] gate_cnt;
	logic [FREQ_W-1:0] edge_cnt;

	// probe is asynchronous to hw.
	assign rise = sync[1] && !probe_d;

	always_ff @(posedge hw) begin
		if (reset) begin
			sync <= '0;
			probe_d <= 1'b0;
			gate_cnt <= '0;
			edge_cnt <= '0;
			freq <= '0;
		end else begin
			sync <= {sync[0], probe};
			probe_d <= sync[1];
			if (gate_cnt == FREQ_GATE_W'(FREQ_GATE - 1)) begin
				// gate boundary, publish and restart.
				gate_cnt <= '0;
				freq <= edge_cnt + FREQ_W'(rise);
				edge_cnt <= '0;
			end else begin
				gate_cnt <= gate_cnt + 1'b1;
				edge_cnt <= edge_cnt + FREQ_W'(rise);
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/axil_regs.sv
`timescale 1ns/1ps
`default_nettype none

module axil_regs import boardcfg_pkg::*; (
	input wire logic hw,
	input wire logic reset,
	input wire axil_req_t req,
	output axil_rsp_t rsp,
	output coef_matrix_t coef,
	output logic [NSHOT_W-1:0] nshot,
	output logic start,
	output logic acc_clear,
	input wire logic busy,
	input wire logic last_shot_done,
	input wire logic [NSHOT_W-1:0] shot_cnt,
	input wire logic [ACC_W-1:0] acc,
	input wire logic [NPROBE-1:0][FREQ_W-1:0] freq,
	output logic [7:0] leds
);

	logic bvalid;
	logic rvalid;
	logic [AXIL_DATA_W-1:0] rdata;
	logic [7:0] test_reg;
	logic wr_hs;
	logic rd_hs;
	logic [AXIL_ADDR_W-1:0] wr_addr;
	logic [AXIL_ADDR_W-1:0] rd_addr;
	logic [AXIL_DATA_W-1:0] rd_word;

	// byte-lane merge into a 16-bit register.
	function automatic logic [15:0] merge_lo16(
		input logic [15:0] cur,
		input logic [AXIL_DATA_W-1:0] data,
		input logic [AXIL_DATA_W/8-1:0] strb
	);
		logic [15:0] res;
		res = cur;
		if (strb[0])
			res[7:0] = data[7:0];
		if (strb[1])
			res[15:8] = data[15:8];
		return res;
	endfunction

	// address and data taken together, one write outstanding.
	assign wr_hs = req.awvalid && req.wvalid && !bvalid;
	assign rd_hs = req.arvalid && !rvalid;
	assign wr_addr = {req.awaddr[AXIL_ADDR_W-1:2], 2'b00};
	assign rd_addr = {req.araddr[AXIL_ADDR_W-1:2], 2'b00};

	always_comb begin
		rsp.awready = wr_hs;
		rsp.wready = wr_hs;
		rsp.bvalid = bvalid;
		rsp.bresp = 2'b00;
		rsp.arready = !rvalid;
		rsp.rvalid = rvalid;
		rsp.rdata = rdata;
		rsp.rresp = 2'b00;
	end

	always_ff @(posedge hw) begin
		if (reset) begin
			bvalid <= 1'b0;
		end else if (wr_hs) begin
			bvalid <= 1'b1;
		end else if (req.bready) begin
			bvalid <= 1'b0;
		end
	end

	// register writes and control strobes.
	always_ff @(posedge hw) begin
		if (reset) begin
			nshot <= '0;
			test_reg <= '0;
			start <= 1'b0;
			acc_clear <= 1'b0;
			for (int r = 0; r < NCH; r++) begin
				for (int c = 0; c < NCH; c++) begin
					coef[r][c] <= (r == c) ? 16'sh4000 : 16'sh0000;
				end
			end
		end else begin
			start <= wr_hs && wr_addr == REG_CTRL && req.wstrb[0] && req.wdata[0];
			acc_clear <= wr_hs && wr_addr == REG_CTRL && req.wstrb[0] && req.wdata[1];
			if (wr_hs) begin
				if (wr_addr == REG_NSHOT)
					nshot <= merge_lo16(nshot, req.wdata, req.wstrb);
				if (wr_addr == REG_TEST && req.wstrb[0])
					test_reg <= req.wdata[7:0];
				// coefficient block, row in [5:4], col in [3:2].
				if (wr_addr[7:6] == REG_COEF0[7:6])
					coef[wr_addr[5:4]][wr_addr[3:2]] <= merge_lo16(
						coef[wr_addr[5:4]][wr_addr[3:2]], req.wdata, req.wstrb);
			end
		end
	end

	assign leds = test_reg;

	// read decode.
	always_comb begin
		rd_word = '0;
		case (rd_addr)
			REG_REV: rd_word = BOARD_REV;
			REG_NSHOT: rd_word = {{(AXIL_DATA_W-NSHOT_W){1'b0}}, nshot};
			REG_STATUS: rd_word = {shot_cnt, 14'b0, busy, last_shot_done};
			REG_ACC: rd_word = acc;
			REG_TEST: rd_word = {24'b0, test_reg};
			default: begin
				if (rd_addr[7:4] == REG_FREQ0[7:4])
					rd_word = freq[rd_addr[3:2]];
				else if (rd_addr[7:6] == REG_COEF0[7:6])
					rd_word = {{(AXIL_DATA_W-COEF_W){coef[rd_addr[5:4]][rd_addr[3:2]][COEF_W-1]}},
						coef[rd_addr[5:4]][rd_addr[3:2]]};
			end
		endcase
	end

	always_ff @(posedge hw) begin
		if (reset) begin
			rvalid <= 1'b0;
		end else if (rd_hs) begin
			rvalid <= 1'b1;
		end else if (req.rready) begin
			rvalid <= 1'b0;
		end
	end

	// read data captured at the address handshake.
	always_ff @(posedge hw) begin
		if (rd_hs)
			rdata <= rd_word;
	end

endmodule

`default_nettype wire

// File: hw/boardcfg_pkg.sv
`default_nettype none

package boardcfg_pkg;

	// host bus sizes.
	localparam int AXIL_ADDR_W = 8;
	localparam int AXIL_DATA_W = 32;

	// datapath sizes.
	localparam int NCH = 4;
	localparam int NPROBE = 4;
	localparam int SAMPLE_W = 16;
	localparam int COEF_W = 16;
	localparam int COEF_FRAC = 14;
	localparam int PROD_W = SAMPLE_W + COEF_W;
	localparam int SUM_W = PROD_W + $clog2(NCH);

	// probe frequency counting.
	localparam int FREQ_GATE = 256;
	localparam int FREQ_GATE_W = $clog2(FREQ_GATE);
	localparam int FREQ_W = 32;

	// shot sequencing.
	localparam int SHOT_LEN = 16;
	localparam int FRAME_CNT_W = $clog2(SHOT_LEN);
	localparam int NSHOT_W = 16;
	localparam int ACC_W = 32;

	localparam logic [AXIL_DATA_W-1:0] BOARD_REV = 32'h0001_0300;

	// register map, byte offsets.
	localparam logic [AXIL_ADDR_W-1:0] REG_REV = 8'h00;
	localparam logic [AXIL_ADDR_W-1:0] REG_CTRL = 8'h04;
	localparam logic [AXIL_ADDR_W-1:0] REG_NSHOT = 8'h08;
	localparam logic [AXIL_ADDR_W-1:0] REG_STATUS = 8'h0C;
	localparam logic [AXIL_ADDR_W-1:0] REG_ACC = 8'h10;
	localparam logic [AXIL_ADDR_W-1:0] REG_TEST = 8'h14;
	localparam logic [AXIL_ADDR_W-1:0] REG_FREQ0 = 8'h20;
	localparam logic [AXIL_ADDR_W-1:0] REG_COEF0 = 8'h40;

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [COEF_W-1:0] coef_t;

	typedef struct packed {
		logic valid;
		sample_t [NCH-1:0] data;
	} sample_frame_t;

	// indexed as [row][col].
	typedef coef_t [NCH-1:0][NCH-1:0] coef_matrix_t;

	typedef struct packed {
		logic awvalid;
		logic [AXIL_ADDR_W-1:0] awaddr;
		logic wvalid;
		logic [AXIL_DATA_W-1:0] wdata;
		logic [AXIL_DATA_W/8-1:0] wstrb;
		logic bready;
		logic arvalid;
		logic [AXIL_ADDR_W-1:0] araddr;
		logic rready;
	} axil_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		logic [1:0] bresp;
		logic arready;
		logic rvalid;
		logic [AXIL_DATA_W-1:0] rdata;
		logic [1:0] rresp;
	} axil_rsp_t;

endpackage

`default_nettype wire
